/* hw/mac_attach_pkg.sv */
// Widths, vector types, register map and constants shared by every MAC attachment module
package mac_attach_pkg;

  // ----------------------------------------
  // Stream widths
  localparam int DATA_W  = 64;
  localparam int KEEP_W  = DATA_W / 8;
  localparam int TUSER_W = 32;
  localparam int PORT_W  = 8;

  // Source port field position inside TUSER
  localparam int TUSER_SRC_LSB = 16;

  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [KEEP_W-1:0]  keep_t;
  typedef logic [TUSER_W-1:0] tuser_t;
  typedef logic [PORT_W-1:0]  port_t;

  // ----------------------------------------
  // Register bus
  localparam int WB_ADR_W = 8;
  localparam int WB_DAT_W = 32;
  localparam int CNT_W    = 32;

  typedef logic [WB_ADR_W-1:0] wb_adr_t;
  typedef logic [WB_DAT_W-1:0] wb_dat_t;
  // Bit 31 sticky overflow, bits 30:0 count
  typedef logic [CNT_W-1:0]    cnt_t;
  // Word index, byte address over 4
  typedef logic [WB_ADR_W-3:0] reg_idx_t;

  // Queue sizes in beats, pointers carry one extra wrap bit
  localparam int RX_DEPTH = 64;
  localparam int TX_DEPTH = 64;
  localparam int RX_PTR_W = $clog2(RX_DEPTH);
  localparam int TX_PTR_W = $clog2(TX_DEPTH);

  typedef logic [RX_PTR_W:0] rx_ptr_t;
  typedef logic [TX_PTR_W:0] tx_ptr_t;

  // Packet counters
  localparam int NUM_CNT     = 3;
  localparam int CNT_RX_MAC  = 0;
  localparam int CNT_RX_DROP = 1;
  localparam int CNT_TX_MAC  = 2;

  // Register map
  localparam reg_idx_t REG_ID       = 'd0;
  localparam reg_idx_t REG_VERSION  = 'd1;
  localparam reg_idx_t REG_RESET    = 'd2;
  localparam reg_idx_t REG_FLIP     = 'd3;
  localparam reg_idx_t REG_DEBUG    = 'd4;
  localparam reg_idx_t REG_CNT_BASE = 'd5;

  localparam wb_dat_t ID_VALUE      = 32'h0000_DA01;
  localparam wb_dat_t VERSION_VALUE = 32'h0000_0100;
  localparam wb_dat_t DEBUG_BASE    = 32'h1000_0000;

endpackage

/* hw/pkt_stat_counters.sv */
// Packet counters with sticky overflow bit, per-counter clear and global clear
`timescale 1ns/1ps

module pkt_stat_counters
  import mac_attach_pkg::*;
(
  input  logic               axis_aclk,
  input  logic               i_arst_n,
  input  logic [NUM_CNT-1:0] i_event,
  input  logic               i_clear_all,
  input  logic [NUM_CNT-1:0] i_clear,
  output cnt_t               o_count [NUM_CNT]
);

  // ----------------------------------------
  // One counter per event bit
  for (genvar g = 0; g < NUM_CNT; g++) begin : g_cnt
    logic [CNT_W-2:0] count_q;
    logic             ovf_q;
    logic             wrap;

    // Count is about to roll over to zero
    assign wrap = i_event[g] && (&count_q);

    always_ff @(posedge axis_aclk or negedge i_arst_n) begin
      if (!i_arst_n) begin
        count_q <= '0;
        ovf_q   <= 1'b0;
      end else if (i_clear_all || i_clear[g]) begin
        // Clear wins over an event in the same cycle
        count_q <= '0;
        ovf_q   <= 1'b0;
      end else begin
        if (i_event[g]) begin
          count_q <= count_q + 1'b1;
        end
        if (wrap) begin
          ovf_q <= 1'b1;
        end
      end
    end

    assign o_count[g] = {ovf_q, count_q};
  end

endmodule

/* hw/rx_packet_queue.sv */
// Receive frame queue from the MAC, commits or drops whole frames and stamps the source port
`timescale 1ns/1ps

module rx_packet_queue
  import mac_attach_pkg::*;
(
  input  logic   axis_aclk,
  input  logic   i_arst_n,
  // MAC receive stream, no back-pressure
  input  data_t  i_mac_rx_tdata,
  input  keep_t  i_mac_rx_tkeep,
  input  logic   i_mac_rx_tvalid,
  input  logic   i_mac_rx_tlast,
  input  logic   i_mac_rx_tuser_err,
  input  port_t  i_interface_number,
  // Pipeline receive stream
  output data_t  o_pipe_rx_tdata,
  output keep_t  o_pipe_rx_tkeep,
  output tuser_t o_pipe_rx_tuser,
  output logic   o_pipe_rx_tvalid,
  output logic   o_pipe_rx_tlast,
  input  logic   i_pipe_rx_tready,
  // Frame status pulses
  output logic   o_frame_seen,
  output logic   o_frame_drop
);

  data_t mem_data [RX_DEPTH];
  keep_t mem_keep [RX_DEPTH];
  logic  mem_last [RX_DEPTH];

  rx_ptr_t wr_commit_ptr;
  rx_ptr_t wr_tent_ptr;
  rx_ptr_t rd_ptr;
  logic    frame_dropped;
  logic    out_valid;

  logic [RX_PTR_W+1:0] used_beats;
  logic                queue_full;
  logic                beat_lost;
  logic                frame_bad;
  logic                wr_en;
  logic                load_out;

  // ----------------------------------------
  // Write side
  // The beat held at the output still occupies a slot
  assign used_beats = {1'b0, rx_ptr_t'(wr_tent_ptr - rd_ptr)} + (RX_PTR_W+2)'(out_valid);
  assign queue_full = (used_beats == (RX_PTR_W+2)'(RX_DEPTH));
  assign beat_lost  = frame_dropped || queue_full;
  assign frame_bad  = beat_lost || i_mac_rx_tuser_err;
  assign wr_en      = i_mac_rx_tvalid && !beat_lost;

  always_ff @(posedge axis_aclk) begin
    if (wr_en) begin
      mem_data[wr_tent_ptr[RX_PTR_W-1:0]] <= i_mac_rx_tdata;
      mem_keep[wr_tent_ptr[RX_PTR_W-1:0]] <= i_mac_rx_tkeep;
      mem_last[wr_tent_ptr[RX_PTR_W-1:0]] <= i_mac_rx_tlast;
    end
  end

  always_ff @(posedge axis_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_commit_ptr <= '0;
      wr_tent_ptr   <= '0;
      frame_dropped <= 1'b0;
      o_frame_seen  <= 1'b0;
      o_frame_drop  <= 1'b0;
    end else begin
      o_frame_seen <= i_mac_rx_tvalid && i_mac_rx_tlast;
      o_frame_drop <= i_mac_rx_tvalid && i_mac_rx_tlast && frame_bad;
      if (i_mac_rx_tvalid) begin
        if (i_mac_rx_tlast) begin
          frame_dropped <= 1'b0;
          if (frame_bad) begin
            // Roll back to the end of the last good frame
            wr_tent_ptr <= wr_commit_ptr;
          end else begin
            wr_tent_ptr   <= wr_tent_ptr + 1'b1;
            wr_commit_ptr <= wr_tent_ptr + 1'b1;
          end
        end else if (beat_lost) begin
          // Rest of this frame is discarded
          frame_dropped <= 1'b1;
        end else begin
          wr_tent_ptr <= wr_tent_ptr + 1'b1;
        end
      end
    end
  end

  // ----------------------------------------
  // Read side, one output register stage
  assign load_out = (rd_ptr != wr_commit_ptr) && (!out_valid || i_pipe_rx_tready);

  always_ff @(posedge axis_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_ptr    <= '0;
      out_valid <= 1'b0;
    end else if (load_out) begin
      rd_ptr    <= rd_ptr + 1'b1;
      out_valid <= 1'b1;
    end else if (i_pipe_rx_tready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (load_out) begin
      o_pipe_rx_tdata <= mem_data[rd_ptr[RX_PTR_W-1:0]];
      o_pipe_rx_tkeep <= mem_keep[rd_ptr[RX_PTR_W-1:0]];
      o_pipe_rx_tlast <= mem_last[rd_ptr[RX_PTR_W-1:0]];
    end
  end

  assign o_pipe_rx_tvalid = out_valid;
  // Source port in bits 23:16, everything else zero
  assign o_pipe_rx_tuser  = tuser_t'(i_interface_number) << TUSER_SRC_LSB;

endmodule

/* hw/tx_packet_queue.sv */
// Store-and-forward transmit queue, starts a frame toward the MAC only once fully stored
`timescale 1ns/1ps

module tx_packet_queue
  import mac_attach_pkg::*;
(
  input  logic  axis_aclk,
  input  logic  i_arst_n,
  // Pipeline transmit stream
  input  data_t i_pipe_tx_tdata,
  input  keep_t i_pipe_tx_tkeep,
  input  logic  i_pipe_tx_tvalid,
  input  logic  i_pipe_tx_tlast,
  output logic  o_pipe_tx_tready,
  // MAC transmit stream
  output data_t o_mac_tx_tdata,
  output keep_t o_mac_tx_tkeep,
  output logic  o_mac_tx_tvalid,
  output logic  o_mac_tx_tlast,
  input  logic  i_mac_tx_tready,
  output logic  o_frame_sent
);

  typedef enum logic {TX_IDLE, TX_SEND} tx_state_t;

  data_t mem_data [TX_DEPTH];
  keep_t mem_keep [TX_DEPTH];
  logic  mem_last [TX_DEPTH];

  tx_ptr_t   wr_ptr;
  tx_ptr_t   rd_ptr;
  tx_ptr_t   frames_held;
  tx_state_t state;
  logic      rdy_en;
  logic      in_fire;
  logic      in_eof;
  logic      out_fire;
  logic      out_eof;

  // Input ready held low for the first cycle out of reset
  assign o_pipe_tx_tready = rdy_en && (tx_ptr_t'(wr_ptr - rd_ptr) != tx_ptr_t'(TX_DEPTH));
  assign in_fire          = i_pipe_tx_tvalid && o_pipe_tx_tready;
  assign in_eof           = in_fire && i_pipe_tx_tlast;

  assign o_mac_tx_tvalid = (state == TX_SEND);
  assign o_mac_tx_tdata  = mem_data[rd_ptr[TX_PTR_W-1:0]];
  assign o_mac_tx_tkeep  = mem_keep[rd_ptr[TX_PTR_W-1:0]];
  assign o_mac_tx_tlast  = mem_last[rd_ptr[TX_PTR_W-1:0]];
  assign out_fire        = o_mac_tx_tvalid && i_mac_tx_tready;
  assign out_eof         = out_fire && o_mac_tx_tlast;

  always_ff @(posedge axis_aclk) begin
    if (in_fire) begin
      mem_data[wr_ptr[TX_PTR_W-1:0]] <= i_pipe_tx_tdata;
      mem_keep[wr_ptr[TX_PTR_W-1:0]] <= i_pipe_tx_tkeep;
      mem_last[wr_ptr[TX_PTR_W-1:0]] <= i_pipe_tx_tlast;
    end
  end

  always_ff @(posedge axis_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rdy_en       <= 1'b0;
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      frames_held  <= '0;
      state        <= TX_IDLE;
      o_frame_sent <= 1'b0;
    end else begin
      rdy_en       <= 1'b1;
      o_frame_sent <= out_eof;
      if (in_fire) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (out_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Complete frames currently stored
      case ({in_eof, out_eof})
        2'b10:   frames_held <= frames_held + 1'b1;
        2'b01:   frames_held <= frames_held - 1'b1;
        default: frames_held <= frames_held;
      endcase
      case (state)
        TX_IDLE: begin
          if (frames_held != '0) begin
            state <= TX_SEND;
          end
        end
        TX_SEND: begin
          // Stay in send when another full frame is waiting
          if (out_eof && frames_held == tx_ptr_t'(1)) begin
            state <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

endmodule

/* hw/wb_reg_block.sv */
// Wishbone classic register file with ID, version, reset, test registers and counter readout
`timescale 1ns/1ps

module wb_reg_block
  import mac_attach_pkg::*;
(
  input  logic               axis_aclk,
  input  logic               i_arst_n,
  // Wishbone classic slave
  input  logic               i_wb_cyc,
  input  logic               i_wb_stb,
  input  logic               i_wb_we,
  input  wb_adr_t            i_wb_adr,
  input  wb_dat_t            i_wb_dat,
  output wb_dat_t            o_wb_dat,
  output logic               o_wb_ack,
  // Counter readout and clear
  input  cnt_t               i_count [NUM_CNT],
  output logic               o_clear_all,
  output logic [NUM_CNT-1:0] o_clear
);

  reg_idx_t word_idx;
  wb_dat_t  flip_q;
  wb_dat_t  debug_q;
  wb_dat_t  rd_data;
  logic     req;
  logic     wr_req;

  assign word_idx = i_wb_adr[WB_ADR_W-1:2];
  // New request only while no ack is pending
  assign req      = i_wb_cyc && i_wb_stb && !o_wb_ack;
  assign wr_req   = req && i_wb_we;

  // ----------------------------------------
  // Read mux
  always_comb begin
    rd_data = '0;
    case (word_idx)
      REG_ID:      rd_data = ID_VALUE;
      REG_VERSION: rd_data = VERSION_VALUE;
      REG_FLIP:    rd_data = ~flip_q;
      REG_DEBUG:   rd_data = DEBUG_BASE + debug_q;
      default:     rd_data = '0;
    endcase
    for (int i = 0; i < NUM_CNT; i++) begin
      if (word_idx == reg_idx_t'(REG_CNT_BASE + i)) begin
        rd_data = i_count[i];
      end
    end
  end

  // Read data captured on the cycle the ack goes out
  always_ff @(posedge axis_aclk) begin
    if (req) begin
      o_wb_dat <= rd_data;
    end
  end

  // ----------------------------------------
  // Ack, writes and clear pulses
  always_ff @(posedge axis_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_wb_ack    <= 1'b0;
      flip_q      <= '0;
      debug_q     <= '0;
      o_clear_all <= 1'b0;
      o_clear     <= '0;
    end else begin
      o_wb_ack    <= req;
      o_clear_all <= wr_req && (word_idx == REG_RESET) && i_wb_dat[0];
      for (int i = 0; i < NUM_CNT; i++) begin
        o_clear[i] <= wr_req && (word_idx == reg_idx_t'(REG_CNT_BASE + i));
      end
      if (wr_req && (word_idx == REG_FLIP)) begin
        flip_q <= i_wb_dat;
      end
      if (wr_req && (word_idx == REG_DEBUG)) begin
        debug_q <= i_wb_dat;
      end
    end
  end

endmodule

/* hw/mac_attachment.sv */
// Top level of the MAC attachment, joins the RX and TX queues, counters and register file
`timescale 1ns/1ps

module mac_attachment
  import mac_attach_pkg::*;
(
  input  logic    axis_aclk,
  input  logic    i_arst_n,
  // MAC receive stream
  input  data_t   i_mac_rx_tdata,
  input  keep_t   i_mac_rx_tkeep,
  input  logic    i_mac_rx_tvalid,
  input  logic    i_mac_rx_tlast,
  input  logic    i_mac_rx_tuser_err,
  input  port_t   i_interface_number,
  // Pipeline receive stream
  output data_t   o_pipe_rx_tdata,
  output keep_t   o_pipe_rx_tkeep,
  output tuser_t  o_pipe_rx_tuser,
  output logic    o_pipe_rx_tvalid,
  output logic    o_pipe_rx_tlast,
  input  logic    i_pipe_rx_tready,
  // Pipeline transmit stream
  input  data_t   i_pipe_tx_tdata,
  input  keep_t   i_pipe_tx_tkeep,
  input  logic    i_pipe_tx_tvalid,
  input  logic    i_pipe_tx_tlast,
  output logic    o_pipe_tx_tready,
  // MAC transmit stream
  output data_t   o_mac_tx_tdata,
  output keep_t   o_mac_tx_tkeep,
  output logic    o_mac_tx_tvalid,
  output logic    o_mac_tx_tlast,
  input  logic    i_mac_tx_tready,
  // Wishbone register port
  input  logic    i_wb_cyc,
  input  logic    i_wb_stb,
  input  logic    i_wb_we,
  input  wb_adr_t i_wb_adr,
  input  wb_dat_t i_wb_dat,
  output wb_dat_t o_wb_dat,
  output logic    o_wb_ack
);

  logic               rx_frame_seen;
  logic               rx_frame_drop;
  logic               tx_frame_sent;
  logic [NUM_CNT-1:0] cnt_event;
  logic               cnt_clear_all;
  logic [NUM_CNT-1:0] cnt_clear;
  cnt_t               cnt_value [NUM_CNT];

  // ----------------------------------------
  // Datapath queues
  rx_packet_queue u_rx_queue (
    .axis_aclk          (axis_aclk),
    .i_arst_n           (i_arst_n),
    .i_mac_rx_tdata     (i_mac_rx_tdata),
    .i_mac_rx_tkeep     (i_mac_rx_tkeep),
    .i_mac_rx_tvalid    (i_mac_rx_tvalid),
    .i_mac_rx_tlast     (i_mac_rx_tlast),
    .i_mac_rx_tuser_err (i_mac_rx_tuser_err),
    .i_interface_number (i_interface_number),
    .o_pipe_rx_tdata    (o_pipe_rx_tdata),
    .o_pipe_rx_tkeep    (o_pipe_rx_tkeep),
    .o_pipe_rx_tuser    (o_pipe_rx_tuser),
    .o_pipe_rx_tvalid   (o_pipe_rx_tvalid),
    .o_pipe_rx_tlast    (o_pipe_rx_tlast),
    .i_pipe_rx_tready   (i_pipe_rx_tready),
    .o_frame_seen       (rx_frame_seen),
    .o_frame_drop       (rx_frame_drop)
  );

  tx_packet_queue u_tx_queue (
    .axis_aclk        (axis_aclk),
    .i_arst_n         (i_arst_n),
    .i_pipe_tx_tdata  (i_pipe_tx_tdata),
    .i_pipe_tx_tkeep  (i_pipe_tx_tkeep),
    .i_pipe_tx_tvalid (i_pipe_tx_tvalid),
    .i_pipe_tx_tlast  (i_pipe_tx_tlast),
    .o_pipe_tx_tready (o_pipe_tx_tready),
    .o_mac_tx_tdata   (o_mac_tx_tdata),
    .o_mac_tx_tkeep   (o_mac_tx_tkeep),
    .o_mac_tx_tvalid  (o_mac_tx_tvalid),
    .o_mac_tx_tlast   (o_mac_tx_tlast),
    .i_mac_tx_tready  (i_mac_tx_tready),
    .o_frame_sent     (tx_frame_sent)
  );

  // ----------------------------------------
  // Statistics and registers
  assign cnt_event[CNT_RX_MAC]  = rx_frame_seen;
  assign cnt_event[CNT_RX_DROP] = rx_frame_drop;
  assign cnt_event[CNT_TX_MAC]  = tx_frame_sent;

  pkt_stat_counters u_counters (
    .axis_aclk   (axis_aclk),
    .i_arst_n    (i_arst_n),
    .i_event     (cnt_event),
    .i_clear_all (cnt_clear_all),
    .i_clear     (cnt_clear),
    .o_count     (cnt_value)
  );

  wb_reg_block u_regs (
    .axis_aclk   (axis_aclk),
    .i_arst_n    (i_arst_n),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_we     (i_wb_we),
    .i_wb_adr    (i_wb_adr),
    .i_wb_dat    (i_wb_dat),
    .o_wb_dat    (o_wb_dat),
    .o_wb_ack    (o_wb_ack),
    .i_count     (cnt_value),
    .o_clear_all (cnt_clear_all),
    .o_clear     (cnt_clear)
  );

endmodule

/* verification/mac_attachment_tb_tasks.svh */
// Checking, Wishbone, frame-driving and frame-collecting tasks, included inside the testbench module
`ifndef MAC_ATTACHMENT_TB_TASKS_SVH
`define MAC_ATTACHMENT_TB_TASKS_SVH

// ----------------------------------------
// Value checks
task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
  checks++;
  if (exp !== act) begin
    errors++;
    $display("Fail %s expected %0h actual %0h", name, exp, act);
  end
endtask

// ----------------------------------------
// Wishbone classic master
task automatic wb_access(input logic we, input int idx, input wb_dat_t wdata,
                         output wb_dat_t rdata);
  int n;
  int acks;
  rdata = '0;
  n = 0;
  @(negedge axis_aclk);
  i_wb_cyc = 1'b1;
  i_wb_stb = 1'b1;
  i_wb_we  = we;
  i_wb_adr = wb_adr_t'(idx * 4);
  i_wb_dat = wdata;
  do begin
    @(posedge axis_aclk);
    n++;
  end while (!o_wb_ack && n < TIMEOUT);
  if (!o_wb_ack) begin
    abort_on_timeout("a Wishbone ack");
  end
  rdata = o_wb_dat;
  acks  = 1;
  @(negedge axis_aclk);
  i_wb_cyc = 1'b0;
  i_wb_stb = 1'b0;
  i_wb_we  = 1'b0;
  // A second ack here would mean the access was acknowledged twice
  @(posedge axis_aclk);
  if (o_wb_ack) begin
    acks++;
  end
  check_value("wb ack count", 1, acks);
endtask

task automatic wb_write(input int idx, input wb_dat_t data);
  wb_dat_t unused;
  wb_access(1'b1, idx, data, unused);
endtask

task automatic wb_read_check(input string name, input int idx, input wb_dat_t exp);
  wb_dat_t rd;
  wb_access(1'b0, idx, '0, rd);
  check_value(name, exp, rd);
endtask

// Counters settle two cycles after their event
task automatic check_counters(input string name);
  wb_dat_t rd;
  int      i;
  repeat (3) @(negedge axis_aclk);
  for (i = 0; i < NUM_CNT; i++) begin
    wb_access(1'b0, REG_CNT_BASE + i, '0, rd);
    check_value($sformatf("%s counter %0d", name, i), exp_cnt[i], rd);
  end
endtask

// ----------------------------------------
// Random beats
function automatic data_t random_data();
  logic [31:0] hi;
  logic [31:0] lo;
  hi = $random(seed);
  lo = $random(seed);
  return {hi, lo};
endfunction

// Last beat keeps a run of low bytes, upper bytes empty
function automatic keep_t random_keep(input logic last);
  int gap;
  gap = $random(seed) & 7;
  if (last) begin
    return keep_t'(8'hFF >> gap);
  end
  return '1;
endfunction

// ----------------------------------------
// Frame drivers
task automatic send_rx_frame(input logic bad);
  int    len;
  int    i;
  logic  kept;
  data_t d;
  keep_t k;
  len = 1 + ($random(seed) & 15);
  // Beats still expected are exactly the beats the queue holds
  kept = !bad && (exp_rx_data.size() + len <= RX_DEPTH);
  exp_cnt[CNT_RX_MAC]++;
  if (!kept) begin
    exp_cnt[CNT_RX_DROP]++;
  end
  for (i = 0; i < len; i++) begin
    d = random_data();
    k = random_keep(i == len - 1);
    @(negedge axis_aclk);
    i_mac_rx_tvalid    = 1'b1;
    i_mac_rx_tdata     = d;
    i_mac_rx_tkeep     = k;
    i_mac_rx_tlast     = (i == len - 1);
    i_mac_rx_tuser_err = bad && (i == len - 1);
    if (kept) begin
      exp_rx_data.push_back(d);
      exp_rx_keep.push_back(k);
      exp_rx_last.push_back(i == len - 1);
    end
  end
  @(negedge axis_aclk);
  i_mac_rx_tvalid    = 1'b0;
  i_mac_rx_tlast     = 1'b0;
  i_mac_rx_tuser_err = 1'b0;
endtask

task automatic send_tx_frame();
  int    len;
  int    i;
  int    n;
  data_t d;
  keep_t k;
  len = 1 + ($random(seed) & 15);
  for (i = 0; i < len; i++) begin
    d = random_data();
    k = random_keep(i == len - 1);
    @(negedge axis_aclk);
    i_pipe_tx_tvalid = 1'b1;
    i_pipe_tx_tdata  = d;
    i_pipe_tx_tkeep  = k;
    i_pipe_tx_tlast  = (i == len - 1);
    exp_tx_data.push_back(d);
    exp_tx_keep.push_back(k);
    exp_tx_last.push_back(i == len - 1);
    n = 0;
    do begin
      @(posedge axis_aclk);
      n++;
    end while (!o_pipe_tx_tready && n < TIMEOUT);
    if (!o_pipe_tx_tready) begin
      abort_on_timeout("the transmit queue to accept a beat");
    end
  end
  tx_done++;
  exp_cnt[CNT_TX_MAC]++;
  @(negedge axis_aclk);
  i_pipe_tx_tvalid = 1'b0;
  i_pipe_tx_tlast  = 1'b0;
endtask

task automatic wait_for_drain();
  int n;
  n = 0;
  while ((exp_rx_data.size() != 0 || exp_tx_data.size() != 0) && n < TIMEOUT) begin
    @(negedge axis_aclk);
    n++;
  end
  if (exp_rx_data.size() != 0 || exp_tx_data.size() != 0) begin
    abort_on_timeout("all expected frames to come out");
  end
endtask

// ----------------------------------------
// Frame collectors, called on every rising edge
task automatic collect_rx_beat();
  if (o_pipe_rx_tvalid && i_pipe_rx_tready) begin
    if (exp_rx_data.size() == 0) begin
      errors++;
      $display("Error: a receive beat reached the pipeline when none was expected");
    end else begin
      check_value("rx tdata", exp_rx_data.pop_front(), o_pipe_rx_tdata);
      check_value("rx tkeep", exp_rx_keep.pop_front(), o_pipe_rx_tkeep);
      check_value("rx tlast", exp_rx_last.pop_front(), o_pipe_rx_tlast);
      check_value("rx tuser", {8'h00, PORT_NUM, 16'h0000}, o_pipe_rx_tuser);
    end
  end
endtask

task automatic collect_tx_beat();
  if (tx_in_frame && !o_mac_tx_tvalid) begin
    errors++;
    $display("Error: MAC transmit valid dropped in the middle of a frame");
  end
  if (o_mac_tx_tvalid && i_mac_tx_tready) begin
    if (!tx_in_frame) begin
      if (tx_started >= tx_done) begin
        errors++;
        $display("Error: a transmit frame started before it was fully stored");
      end
      tx_started++;
    end
    if (exp_tx_data.size() == 0) begin
      errors++;
      $display("Error: a transmit beat reached the MAC when none was expected");
    end else begin
      check_value("tx tdata", exp_tx_data.pop_front(), o_mac_tx_tdata);
      check_value("tx tkeep", exp_tx_keep.pop_front(), o_mac_tx_tkeep);
      check_value("tx tlast", exp_tx_last.pop_front(), o_mac_tx_tlast);
    end
    tx_in_frame = !o_mac_tx_tlast;
  end
endtask

`endif

/* verification/mac_attachment_tb.sv */
// Testbench for the MAC attachment, random frames and register accesses checked against a model
`timescale 1ns/1ps

module mac_attachment_tb
  import mac_attach_pkg::*;
();

  localparam int    TIMEOUT  = 2000;
  localparam port_t PORT_NUM = 8'h05;

  logic    axis_aclk;
  logic    i_arst_n;
  data_t   i_mac_rx_tdata;
  keep_t   i_mac_rx_tkeep;
  logic    i_mac_rx_tvalid;
  logic    i_mac_rx_tlast;
  logic    i_mac_rx_tuser_err;
  port_t   i_interface_number;
  data_t   o_pipe_rx_tdata;
  keep_t   o_pipe_rx_tkeep;
  tuser_t  o_pipe_rx_tuser;
  logic    o_pipe_rx_tvalid;
  logic    o_pipe_rx_tlast;
  logic    i_pipe_rx_tready;
  data_t   i_pipe_tx_tdata;
  keep_t   i_pipe_tx_tkeep;
  logic    i_pipe_tx_tvalid;
  logic    i_pipe_tx_tlast;
  logic    o_pipe_tx_tready;
  data_t   o_mac_tx_tdata;
  keep_t   o_mac_tx_tkeep;
  logic    o_mac_tx_tvalid;
  logic    o_mac_tx_tlast;
  logic    i_mac_tx_tready;
  logic    i_wb_cyc;
  logic    i_wb_stb;
  logic    i_wb_we;
  wb_adr_t i_wb_adr;
  wb_dat_t i_wb_dat;
  wb_dat_t o_wb_dat;
  logic    o_wb_ack;

  // Model state
  int      seed;
  int      ready_seed;
  int      errors      = 0;
  int      checks      = 0;
  int      rx_mode     = 1;
  int      tx_mode     = 1;
  int      tx_done     = 0;
  int      tx_started  = 0;
  logic    tx_in_frame = 1'b0;
  data_t   exp_rx_data [$];
  keep_t   exp_rx_keep [$];
  logic    exp_rx_last [$];
  data_t   exp_tx_data [$];
  keep_t   exp_tx_keep [$];
  logic    exp_tx_last [$];
  cnt_t    exp_cnt [NUM_CNT];
  wb_dat_t word;

  mac_attachment uut (.*);

  always #2 axis_aclk = ~axis_aclk;

  // Ready modes: 0 held low, 1 held high, 2 random
  always @(negedge axis_aclk) begin
    i_pipe_rx_tready = (rx_mode == 2) ? ($random(ready_seed) & 1) : (rx_mode == 1);
    i_mac_tx_tready  = (tx_mode == 2) ? ($random(ready_seed) & 1) : (tx_mode == 1);
  end

  always @(posedge axis_aclk) begin
    collect_rx_beat();
    collect_tx_beat();
  end

  `include "mac_attachment_tb_tasks.svh"

  task automatic finish_run();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    errors++;
    $display("Timeout while waiting for %s", what);
    finish_run();
  endtask

  initial begin
    axis_aclk          = 1'b0;
    i_arst_n           = 1'b0;
    i_mac_rx_tdata     = '0;
    i_mac_rx_tkeep     = '0;
    i_mac_rx_tvalid    = 1'b0;
    i_mac_rx_tlast     = 1'b0;
    i_mac_rx_tuser_err = 1'b0;
    i_interface_number = PORT_NUM;
    i_pipe_rx_tready   = 1'b0;
    i_pipe_tx_tdata    = '0;
    i_pipe_tx_tkeep    = '0;
    i_pipe_tx_tvalid   = 1'b0;
    i_pipe_tx_tlast    = 1'b0;
    i_mac_tx_tready    = 1'b0;
    i_wb_cyc           = 1'b0;
    i_wb_stb           = 1'b0;
    i_wb_we            = 1'b0;
    i_wb_adr           = '0;
    i_wb_dat           = '0;
    foreach (exp_cnt[i]) begin
      exp_cnt[i] = '0;
    end
    seed       = 16379;
    ready_seed = $random(seed);
    repeat (3) @(posedge axis_aclk);
    @(negedge axis_aclk);
    i_arst_n = 1'b1;
    #1;
    check_value("rx valid after reset", 0, o_pipe_rx_tvalid);
    check_value("tx valid after reset", 0, o_mac_tx_tvalid);
    check_value("tx ready after reset", 0, o_pipe_tx_tready);
    check_value("wb ack after reset", 0, o_wb_ack);

    // ----------------------------------------
    // Register constants and test registers
    wb_read_check("id", REG_ID, 32'h0000_DA01);
    wb_read_check("version", REG_VERSION, 32'h0000_0100);
    wb_read_check("flip after reset", REG_FLIP, 32'hFFFF_FFFF);
    wb_read_check("unmapped", 20, 32'h0);
    repeat (4) begin
      word = $random(seed);
      wb_write(REG_FLIP, word);
      wb_read_check("flip", REG_FLIP, ~word);
      word = $random(seed);
      wb_write(REG_DEBUG, word);
      wb_read_check("debug", REG_DEBUG, 32'h1000_0000 + word);
    end
    check_counters("after reset");

    // ----------------------------------------
    // Receive forwarding, then bad frames mixed in
    rx_mode = 2;
    repeat (20) begin
      send_rx_frame(1'b0);
      wait_for_drain();
    end
    check_counters("rx forward");
    repeat (24) begin
      send_rx_frame(($random(seed) & 3) == 0);
      wait_for_drain();
    end
    check_counters("rx bad frames");

    // ----------------------------------------
    // Overflow with the pipeline stalled
    rx_mode = 0;
    repeat (2) @(negedge axis_aclk);
    repeat (12) begin
      send_rx_frame(1'b0);
    end
    rx_mode = 2;
    wait_for_drain();
    check_counters("rx overflow");

    // ----------------------------------------
    // Transmit path with a random MAC ready
    tx_mode = 2;
    repeat (20) begin
      send_tx_frame();
    end
    wait_for_drain();
    check_counters("tx path");

    // ----------------------------------------
    // Counter clearing
    wb_write(REG_CNT_BASE + CNT_RX_DROP, $random(seed));
    exp_cnt[CNT_RX_DROP] = '0;
    check_counters("clear rx drop");
    wb_write(REG_CNT_BASE + CNT_TX_MAC, $random(seed));
    exp_cnt[CNT_TX_MAC] = '0;
    check_counters("clear tx mac");
    wb_write(REG_RESET, 32'h1);
    foreach (exp_cnt[i]) begin
      exp_cnt[i] = '0;
    end
    check_counters("clear all");
    send_rx_frame(1'b0);
    send_rx_frame(1'b1);
    wait_for_drain();
    send_tx_frame();
    wait_for_drain();
    check_counters("count after clear");

    finish_run();
  end

endmodule

/* mac_attachment.f */
+incdir+verification
hw/mac_attach_pkg.sv
hw/pkt_stat_counters.sv
hw/rx_packet_queue.sv
hw/tx_packet_queue.sv
hw/wb_reg_block.sv
hw/mac_attachment.sv
verification/mac_attachment_tb.sv

/* Bender.yml */
package:
  name: mac_attachment

sources:
  - files:
      - hw/mac_attach_pkg.sv
      - hw/pkt_stat_counters.sv
      - hw/rx_packet_queue.sv
      - hw/tx_packet_queue.sv
      - hw/wb_reg_block.sv
      - hw/mac_attachment.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/mac_attachment_tb.sv
